// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_plru.sv
src/dcache_data_array.sv
src/dcache_miss_ctrl.sv
src/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_assertions.sv
verif/dcache_tb.sv

// ==== src/dcache_data_array.sv ====
module dcache_data_array (
    input  logic                clk,
    input  logic                en,
    input  dcache_pkg::strobe_t strobe,
    input  dcache_pkg::way_t    way,
    input  dcache_pkg::index_t  index,
    input  dcache_pkg::offset_t offset,
    input  dcache_pkg::word_t   wdata,
    output dcache_pkg::word_t   rdata
);
    dcache_pkg::word_t mem [dcache_pkg::WAYS][dcache_pkg::SETS][dcache_pkg::WORDS_PER_LINE];

    // read returns the old word, write merges enabled bytes
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[way][index][offset];
            for (int b = 0; b < dcache_pkg::BYTES_PER_WORD; b++) begin
                if (strobe[b]) begin
                    mem[way][index][offset][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/dcache_miss_ctrl.sv ====
module dcache_miss_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp,
    input  logic                  hit,
    input  dcache_pkg::way_t      hit_way,
    input  logic                  victim_valid,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::way_t      victim_way,
    output logic                  touch_en,
    output dcache_pkg::way_t      touch_way,
    output logic                  fill_en,
    output dcache_pkg::way_t      fill_way,
    output logic                  ram_en,
    output dcache_pkg::strobe_t   ram_strobe,
    output dcache_pkg::way_t      ram_way,
    output dcache_pkg::offset_t   ram_offset,
    output dcache_pkg::word_t     ram_wdata,
    input  dcache_pkg::word_t     ram_rdata
);
    typedef logic [dcache_pkg::OFFSET_BITS:0] rd_cnt_t;

    dcache_pkg::ctrl_state_t state;
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] dirty;
    dcache_pkg::word_t wb_buf [dcache_pkg::WORDS_PER_LINE];

    rd_cnt_t                 rd_cnt;
    dcache_pkg::offset_t     rd_slot;
    dcache_pkg::offset_t     beat_cnt;
    dcache_pkg::way_t        victim_q;
    logic                    data_ok_q;
    logic                    bus_gap;
    logic                    accept;
    logic                    beat;
    logic                    victim_dirty;
    dcache_pkg::index_t      index;
    dcache_pkg::cache_addr_u bus_addr;

    assign index        = cpu_req.addr.fields.index;
    assign accept       = (state == dcache_pkg::IDLE) && cpu_req.valid && hit;
    assign victim_dirty = victim_valid && dirty[index][victim_way];
    assign beat         = mem_req.valid && mem_resp.ready;

    // read data lags the issued offset by one
    assign rd_slot = dcache_pkg::offset_t'(rd_cnt - rd_cnt_t'(1));

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= dcache_pkg::IDLE;
            rd_cnt    <= '0;
            beat_cnt  <= '0;
            victim_q  <= '0;
            data_ok_q <= 1'b0;
            bus_gap   <= 1'b0;
        end else begin
            data_ok_q <= accept;
            // one idle cycle on the bus between writeback and fetch
            bus_gap   <= (state == dcache_pkg::WB_BURST) && beat && mem_resp.last;
            case (state)
                dcache_pkg::IDLE: begin
                    if (cpu_req.valid && !hit) begin
                        victim_q <= victim_way;
                        rd_cnt   <= '0;
                        beat_cnt <= '0;
                        state    <= victim_dirty ? dcache_pkg::WB_READ : dcache_pkg::FETCH;
                    end
                end
                dcache_pkg::WB_READ: begin
                    rd_cnt <= rd_cnt + rd_cnt_t'(1);
                    if (rd_cnt[dcache_pkg::OFFSET_BITS]) begin
                        state <= dcache_pkg::WB_BURST;
                    end
                end
                dcache_pkg::WB_BURST: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + dcache_pkg::offset_t'(1);
                        if (mem_resp.last) begin
                            state <= dcache_pkg::FETCH;
                        end
                    end
                end
                dcache_pkg::FETCH: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + dcache_pkg::offset_t'(1);
                        if (mem_resp.last) begin
                            state <= dcache_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    // victim line copy
    always_ff @(posedge clk) begin
        if ((state == dcache_pkg::WB_READ) && (rd_cnt != '0)) begin
            wb_buf[rd_slot] <= ram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            dirty <= '0;
        end else if (accept && (|cpu_req.strobe)) begin
            dirty[index][hit_way] <= 1'b1;
        end else if (fill_en) begin
            dirty[index][victim_q] <= 1'b0;
        end
    end

    assign fill_en   = (state == dcache_pkg::FETCH) && beat && mem_resp.last;
    assign fill_way  = victim_q;
    assign touch_en  = accept || fill_en;
    assign touch_way = accept ? hit_way : victim_q;

    // data array port shared by hits, buffer reads and refill
    always_comb begin
        ram_en     = 1'b0;
        ram_strobe = '0;
        ram_way    = victim_q;
        ram_offset = beat_cnt;
        ram_wdata  = mem_resp.rdata;
        case (state)
            dcache_pkg::IDLE: begin
                ram_en     = accept;
                ram_strobe = cpu_req.strobe;
                ram_way    = hit_way;
                ram_offset = cpu_req.addr.fields.offset;
                ram_wdata  = cpu_req.wdata;
            end
            dcache_pkg::WB_READ: begin
                ram_en     = ~rd_cnt[dcache_pkg::OFFSET_BITS];
                ram_offset = rd_cnt[dcache_pkg::OFFSET_BITS-1:0];
            end
            dcache_pkg::FETCH: begin
                ram_en     = beat;
                ram_strobe = '1;
            end
            default: begin
            end
        endcase
    end

    // line aligned, old tag for writeback
    always_comb begin
        bus_addr.fields.tag    = (state == dcache_pkg::WB_BURST) ? victim_tag
                                                                 : cpu_req.addr.fields.tag;
        bus_addr.fields.index  = index;
        bus_addr.fields.offset = '0;
        bus_addr.fields.align  = '0;
    end

    always_comb begin
        mem_req.valid    = ((state == dcache_pkg::WB_BURST) || (state == dcache_pkg::FETCH))
                           && !bus_gap;
        mem_req.is_write = state == dcache_pkg::WB_BURST;
        mem_req.addr     = bus_addr.raw;
        mem_req.wdata    = wb_buf[beat_cnt];
    end

    always_comb begin
        cpu_resp.addr_ok = accept;
        cpu_resp.data_ok = data_ok_q;
        cpu_resp.rdata   = ram_rdata;
    end

endmodule

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int WAYS           = 4;
    localparam int SETS           = 16;
    localparam int WORDS_PER_LINE = 8;
    localparam int BYTES_PER_WORD = 4;

    // address field widths, 23 + 4 + 3 + 2
    localparam int WAY_BITS    = 2;
    localparam int INDEX_BITS  = 4;
    localparam int OFFSET_BITS = 3;
    localparam int ALIGN_BITS  = 2;
    localparam int TAG_BITS    = 23;

    typedef logic [31:0]               word_t;
    typedef logic [BYTES_PER_WORD-1:0] strobe_t;
    typedef logic [WAY_BITS-1:0]       way_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [OFFSET_BITS-1:0]    offset_t;
    typedef logic [TAG_BITS-1:0]       tag_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } line_addr_t;

    // request address, seen as a raw word or split into fields
    typedef union packed {
        word_t      raw;
        line_addr_t fields;
    } cache_addr_u;

    // read when strobe is all zero
    typedef struct packed {
        logic        valid;
        cache_addr_u addr;
        strobe_t     strobe;
        word_t       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic  valid;
        logic  is_write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t rdata;
    } mem_resp_t;

    // root bit, left half bit, right half bit
    typedef logic [WAYS-2:0] plru_t;

    typedef enum logic [1:0] {
        IDLE,
        WB_READ,
        WB_BURST,
        FETCH
    } ctrl_state_t;

endpackage

// ==== src/dcache_plru.sv ====
module dcache_plru (
    input  logic               clk,
    input  logic               resetn,
    input  dcache_pkg::index_t index,
    input  logic               touch_en,
    input  dcache_pkg::way_t   touch_way,
    output dcache_pkg::way_t   victim_way
);
    dcache_pkg::plru_t [dcache_pkg::SETS-1:0] tree;

    dcache_pkg::plru_t cur;
    dcache_pkg::plru_t next_tree;

    assign cur = tree[index];

    // root picks the half, then that half's bit picks the way
    always_comb begin
        if (cur[0]) begin
            victim_way = {1'b1, cur[2]};
        end else begin
            victim_way = {1'b0, cur[1]};
        end
    end

    // point the path away from the touched way
    always_comb begin
        next_tree    = cur;
        next_tree[0] = ~touch_way[1];
        if (touch_way[1]) begin
            next_tree[2] = ~touch_way[0];
        end else begin
            next_tree[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            tree <= '0;
        end else if (touch_en) begin
            tree[index] <= next_tree;
        end
    end

endmodule

// ==== src/dcache_tag_array.sv ====
module dcache_tag_array (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::cache_addr_u lookup_addr,
    output logic                    hit,
    output dcache_pkg::way_t        hit_way,
    input  dcache_pkg::way_t        victim_way,
    output logic                    victim_valid,
    output dcache_pkg::tag_t        victim_tag,
    input  logic                    fill_en,
    input  dcache_pkg::way_t        fill_way
);
    dcache_pkg::tag_t tags [dcache_pkg::SETS][dcache_pkg::WAYS];
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-1:0] valid;

    dcache_pkg::index_t          index;
    dcache_pkg::tag_t            req_tag;
    logic [dcache_pkg::WAYS-1:0] match;

    assign index   = lookup_addr.fields.index;
    assign req_tag = lookup_addr.fields.tag;

    // compare all ways of the set
    always_comb begin
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            match[w] = valid[index][w] && (tags[index][w] == req_tag);
        end
    end

    assign hit = |match;

    // at most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::WAYS; w++) begin
            if (match[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    // victim info for the writeback address
    assign victim_valid = valid[index][victim_way];
    assign victim_tag   = tags[index][victim_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[index][fill_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[index][fill_way] <= req_tag;
        end
    end

endmodule

// ==== src/dcache_top.sv ====
module dcache_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_resp_t mem_resp
);
    logic                hit;
    dcache_pkg::way_t    hit_way;
    dcache_pkg::way_t    victim_way;
    logic                victim_valid;
    dcache_pkg::tag_t    victim_tag;
    logic                fill_en;
    dcache_pkg::way_t    fill_way;
    logic                touch_en;
    dcache_pkg::way_t    touch_way;
    logic                ram_en;
    dcache_pkg::strobe_t ram_strobe;
    dcache_pkg::way_t    ram_way;
    dcache_pkg::offset_t ram_offset;
    dcache_pkg::word_t   ram_wdata;
    dcache_pkg::word_t   ram_rdata;

    dcache_tag_array tag_array_i (
        .clk          (clk),
        .resetn       (resetn),
        .lookup_addr  (cpu_req.addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag),
        .fill_en      (fill_en),
        .fill_way     (fill_way)
    );

    dcache_plru plru_i (
        .clk        (clk),
        .resetn     (resetn),
        .index      (cpu_req.addr.fields.index),
        .touch_en   (touch_en),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

    dcache_data_array data_array_i (
        .clk    (clk),
        .en     (ram_en),
        .strobe (ram_strobe),
        .way    (ram_way),
        .index  (cpu_req.addr.fields.index),
        .offset (ram_offset),
        .wdata  (ram_wdata),
        .rdata  (ram_rdata)
    );

    dcache_miss_ctrl miss_ctrl_i (
        .clk          (clk),
        .resetn       (resetn),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag),
        .victim_way   (victim_way),
        .touch_en     (touch_en),
        .touch_way    (touch_way),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .ram_en       (ram_en),
        .ram_strobe   (ram_strobe),
        .ram_way      (ram_way),
        .ram_offset   (ram_offset),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

endmodule

// ==== verif/dcache_assertions.sv ====
module dcache_assertions (
    input logic                  clk,
    input logic                  resetn,
    input dcache_pkg::cpu_resp_t cpu_resp,
    input dcache_pkg::mem_req_t  mem_req,
    input dcache_pkg::mem_resp_t mem_resp
);
    localparam int LOW_BITS = dcache_pkg::OFFSET_BITS + dcache_pkg::ALIGN_BITS;

    assert property (@(posedge clk) disable iff (resetn)
        cpu_resp.data_ok == $past(cpu_resp.addr_ok))
        else $error("data_ok did not follow addr_ok by one cycle");

    // request held through the burst
    assert property (@(posedge clk) disable iff (resetn)
        mem_req.valid && !(mem_resp.ready && mem_resp.last) |=>
            mem_req.valid && $stable(mem_req.is_write) && $stable(mem_req.addr))
        else $error("memory request changed before the last beat");

    assert property (@(posedge clk) disable iff (resetn)
        mem_req.valid |-> (mem_req.addr[LOW_BITS-1:0] == '0))
        else $error("memory address is not line aligned");

endmodule

bind dcache_miss_ctrl dcache_assertions assertions_i (
    .clk      (clk),
    .resetn   (resetn),
    .cpu_resp (cpu_resp),
    .mem_req  (mem_req),
    .mem_resp (mem_resp)
);

// ==== verif/dcache_mem_model.sv ====
module dcache_mem_model (
    input  logic                  clk,
    input  logic                  resetn,
    input  dcache_pkg::mem_req_t  mem_req,
    output dcache_pkg::mem_resp_t mem_resp
);
    localparam int DEPTH = 1024;

    // word addressed backing store, read by the testbench
    dcache_pkg::word_t store [DEPTH];

    logic                ready_q = 1'b0;
    dcache_pkg::offset_t cnt     = '0;
    logic                filled  = 1'b0;
    logic [9:0]          word_idx;

    // burst base plus beat number
    assign word_idx = mem_req.addr[11:2] + {7'd0, cnt};

    always_comb begin
        mem_resp.ready = ready_q;
        mem_resp.last  = ready_q && (cnt == 3'd7);
        mem_resp.rdata = store[word_idx];
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            ready_q <= 1'b0;
            cnt     <= '0;
            if (!filled) begin
                for (int a = 0; a < DEPTH; a++) begin
                    store[a] <= $urandom ^ (dcache_pkg::word_t'(a) << 20)
                                ^ dcache_pkg::word_t'(a);
                end
                filled <= 1'b1;
            end
        end else begin
            // stalls about one cycle in four
            ready_q <= ($urandom % 32'd4) != 32'd0;
            if (mem_req.valid && ready_q) begin
                cnt <= cnt + 3'd1;
                if (mem_req.is_write) begin
                    store[word_idx] <= mem_req.wdata;
                end
            end
        end
    end

endmodule

// ==== verif/dcache_tb.sv ====
module dcache_tb;

    localparam int RESET_CYCLES = 10;
    localparam int WORDS        = 1024;

    typedef struct packed {
        logic [3:0]          test;
        logic                is_write;
        dcache_pkg::word_t   addr;
        dcache_pkg::strobe_t strobe;
        dcache_pkg::word_t   wdata;
        logic                expect_bus;
        logic                check_store;
    } row_t;

    logic                  clk;
    logic                  resetn;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::cpu_resp_t cpu_resp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp;

    row_t              rows [$];
    dcache_pkg::word_t shadow [WORDS];
    int                cycle_limit;
    int                cycles;
    int                bus_cycles;
    int                beats;
    int                bursts;
    int                errors;
    int                beat_errors;
    int                checks;

    dcache_top dcache_top_i (
        .clk      (clk),
        .resetn   (resetn),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    dcache_mem_model mem_model_i (
        .clk      (clk),
        .resetn   (resetn),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic dcache_pkg::word_t word_addr(input int tag, input int index,
                                                    input int offset);
        dcache_pkg::cache_addr_u a;
        a.fields.tag    = dcache_pkg::tag_t'(tag);
        a.fields.index  = dcache_pkg::index_t'(index);
        a.fields.offset = dcache_pkg::offset_t'(offset);
        a.fields.align  = '0;
        return a.raw;
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_word,
                                                      input dcache_pkg::word_t new_word,
                                                      input dcache_pkg::strobe_t strobe);
        dcache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic void add_row(input int test, input logic is_write,
                                    input dcache_pkg::word_t addr,
                                    input dcache_pkg::strobe_t strobe,
                                    input dcache_pkg::word_t wdata,
                                    input logic expect_bus, input logic check_store);
        row_t r;
        r.test        = 4'(test);
        r.is_write    = is_write;
        r.addr        = addr;
        r.strobe      = strobe;
        r.wdata       = wdata;
        r.expect_bus  = expect_bus;
        r.check_store = check_store;
        rows.push_back(r);
    endfunction

    // test, write, address, strobe, data, bus traffic, check backing store
    function automatic void build_table();
        add_row(1, 1'b0, word_addr(0, 1, 2), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(2, 1'b0, word_addr(0, 1, 5), 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(2, 1'b1, word_addr(0, 1, 5), 4'b0101, 32'ha1b2_c3d4, 1'b0, 1'b0);
        add_row(2, 1'b1, word_addr(0, 1, 5), 4'b1000, 32'h5e00_0000, 1'b0, 1'b0);
        add_row(2, 1'b0, word_addr(0, 1, 5), 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(2, 1'b0, word_addr(0, 1, 7), 4'h0, 32'h0, 1'b0, 1'b0);
        // set 2 with the first tag dirty until the fifth tag evicts it
        add_row(3, 1'b1, word_addr(1, 2, 3), 4'b0110, 32'h1234_5678, 1'b1, 1'b0);
        add_row(3, 1'b0, word_addr(2, 2, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(3, 1'b0, word_addr(3, 2, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(3, 1'b0, word_addr(4, 2, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(3, 1'b0, word_addr(5, 2, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(3, 1'b0, word_addr(1, 2, 3), 4'h0, 32'h0, 1'b1, 1'b1);
        // set 4 filled with A to D, A touched again before E comes in
        add_row(4, 1'b0, word_addr(1, 4, 1), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(4, 1'b0, word_addr(2, 4, 1), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(4, 1'b0, word_addr(3, 4, 1), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(4, 1'b0, word_addr(4, 4, 1), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(4, 1'b0, word_addr(1, 4, 6), 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(4, 1'b0, word_addr(5, 4, 1), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(4, 1'b0, word_addr(1, 4, 2), 4'h0, 32'h0, 1'b0, 1'b0);
        // set 7 full word write then eviction under stalls
        add_row(5, 1'b1, word_addr(6, 7, 1), 4'hf, 32'hcafe_f00d, 1'b1, 1'b0);
        add_row(5, 1'b0, word_addr(6, 7, 1), 4'h0, 32'h0, 1'b0, 1'b0);
        add_row(5, 1'b0, word_addr(0, 7, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(5, 1'b0, word_addr(1, 7, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(5, 1'b0, word_addr(2, 7, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(5, 1'b0, word_addr(3, 7, 0), 4'h0, 32'h0, 1'b1, 1'b0);
        add_row(5, 1'b0, word_addr(6, 7, 1), 4'h0, 32'h0, 1'b1, 1'b1);
    endfunction

    task automatic apply_row(input row_t r);
        logic [9:0] widx;
        int         bus_start;
        logic       bus_used;

        widx = r.addr[11:2];
        @(posedge clk);
        bus_start        = bus_cycles;
        cpu_req.valid    <= 1'b1;
        cpu_req.addr.raw <= r.addr;
        cpu_req.strobe   <= r.is_write ? r.strobe : 4'h0;
        cpu_req.wdata    <= r.wdata;
        @(negedge clk);
        while (!cpu_resp.addr_ok) begin
            @(negedge clk);
        end
        // request taken at this edge
        @(posedge clk);
        bus_used      = bus_cycles != bus_start;
        cpu_req.valid <= 1'b0;
        @(negedge clk);
        checks++;
        if (!cpu_resp.data_ok) begin
            $display("test %0d: no data_ok one cycle after addr_ok at %h", r.test, r.addr);
            errors++;
        end
        if (r.is_write) begin
            shadow[widx] = merge_bytes(shadow[widx], r.wdata, r.strobe);
        end else begin
            checks++;
            if (cpu_resp.rdata !== shadow[widx]) begin
                $display("Fail rdata: got %h expected %h at address %h",
                         cpu_resp.rdata, shadow[widx], r.addr);
                errors++;
            end
        end
        checks++;
        if (bus_used != r.expect_bus) begin
            $display("test %0d: memory bus %s at address %h", r.test,
                     r.expect_bus ? "stayed idle on a miss" : "was used on a hit", r.addr);
            errors++;
        end
        if (r.check_store) begin
            checks++;
            if (mem_model_i.store[widx] !== shadow[widx]) begin
                $display("Fail store: got %h expected %h at address %h",
                         mem_model_i.store[widx], shadow[widx], r.addr);
                errors++;
            end
        end
    endtask

    // a burst ends where valid drops, so its beats are counted up to there
    always @(negedge clk) begin
        if (mem_req.valid) begin
            bus_cycles++;
            if (mem_resp.ready) begin
                beats++;
            end
        end else if (beats != 0) begin
            bursts++;
            if (beats != 8) begin
                $display("burst %0d carried %0d beats instead of 8", bursts, beats);
                beat_errors++;
            end
            beats = 0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int test_start;

        void'($urandom(32'h67b05e84));
        resetn  = 1'b1;
        cpu_req = '0;
        build_table();
        // two 9-cycle bursts per row plus stall margin
        cycle_limit = RESET_CYCLES + rows.size() * (2 * 9 + 30);
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        checks++;
        if (cpu_resp.addr_ok || cpu_resp.data_ok || mem_req.valid) begin
            $display("addr_ok, data_ok or memory valid high after reset");
            errors++;
        end
        for (int a = 0; a < WORDS; a++) begin
            shadow[a] = mem_model_i.store[a];
        end
        test_start = 0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            if ((i == rows.size() - 1) || (rows[i + 1].test != rows[i].test)) begin
                $display("test %0d done, %0d errors", rows[i].test,
                         errors + beat_errors - test_start);
                test_start = errors + beat_errors;
            end
        end
        $display("%0d checks, %0d bursts, %0d errors", checks, bursts, errors + beat_errors);
        if (errors + beat_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
